// File: common/mipsPkg.sv
package mipsPkg;

    // ==================================================================
    // Sizes
    // ==================================================================
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int memWords     = 64;    // Unified program and data words.
    localparam int mulCycles    = 32;    // One iteration per multiplier bit.

    localparam logic [dataWidth-1:0] resetPc = '0;

    // ==================================================================
    // Encodings
    // ==================================================================
    typedef enum logic [5:0] {
        rType = 6'h00,
        beq   = 6'h04,
        addi  = 6'h08,
        ori   = 6'h0d,
        lw    = 6'h23,
        sw    = 6'h2b
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluSrl,
        aluMul
    } aluOpT;

    // Multicycle sequence states.
    typedef enum logic [3:0] {
        fetch,
        decode,
        memAdr,
        memRead,
        memWriteback,
        memWrite,
        execute,
        mulWait,
        aluWriteback,
        branch,
        immExecute,
        immWriteback
    } stateT;

endpackage

// File: src/controller.sv
`timescale 1ns/1ps

module controller
    import mipsPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  opcodeT     opcode,
    input  logic [5:0] funct,
    input  logic       zero,
    input  logic       aluBusy,
    output logic       pcEn,
    output logic       iorD,
    output logic       irWrite,
    output logic       regDst,
    output logic       memToReg,
    output logic       regWrite,
    output logic       aluSrcA,
    output logic [1:0] aluSrcB,
    output logic       extSel,
    output logic       pcSrc,
    output aluOpT      aluControl,
    output logic       aluStart,
    output logic       memWrite
);

    stateT state;
    stateT nextState;
    aluOpT rTypeOp;

    function automatic aluOpT functToOp(input logic [5:0] f);
        case (f)
            6'h20:   return aluAdd;
            6'h22:   return aluSub;
            6'h24:   return aluAnd;
            6'h25:   return aluOr;
            6'h2a:   return aluSlt;
            6'h00:   return aluSll;
            6'h02:   return aluSrl;
            6'h18:   return aluMul;
            default: return aluAdd;
        endcase
    endfunction

    assign rTypeOp = functToOp(funct);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        pcEn       = 1'b0;
        iorD       = 1'b0;
        irWrite    = 1'b0;
        regDst     = 1'b0;
        memToReg   = 1'b0;
        regWrite   = 1'b0;
        aluSrcA    = 1'b0;
        aluSrcB    = 2'b00;
        extSel     = 1'b0;
        pcSrc      = 1'b0;
        aluControl = aluAdd;              // PC+4 in fetch, branch target in decode.
        aluStart   = 1'b0;
        memWrite   = 1'b0;
        nextState  = fetch;
        case (state)
            fetch: begin
                irWrite   = 1'b1;
                aluSrcB   = 2'b01;
                pcEn      = 1'b1;
                nextState = decode;
            end
            decode: begin
                aluSrcB = 2'b11;
                case (opcode)
                    lw, sw:     nextState = memAdr;
                    rType:      nextState = execute;
                    beq:        nextState = branch;
                    addi, ori:  nextState = immExecute;
                    default:    nextState = fetch;
                endcase
            end
            memAdr: begin
                aluSrcA   = 1'b1;
                aluSrcB   = 2'b10;
                nextState = (opcode == lw) ? memRead : mipsPkg::memWrite;
            end
            memRead: begin
                iorD      = 1'b1;
                nextState = memWriteback;
            end
            memWriteback: begin
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            mipsPkg::memWrite: begin
                iorD     = 1'b1;
                memWrite = 1'b1;
            end
            execute: begin
                aluSrcA    = 1'b1;
                aluControl = rTypeOp;
                aluStart   = (rTypeOp == aluMul);
                nextState  = (rTypeOp == aluMul) ? mulWait : aluWriteback;
            end
            mulWait: begin
                aluControl = aluMul;      // Keeps the product flowing into the output register.
                nextState  = aluBusy ? mulWait : aluWriteback;
            end
            aluWriteback: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            branch: begin
                aluSrcA    = 1'b1;
                aluControl = aluSub;
                pcSrc      = 1'b1;
                pcEn       = zero;
            end
            immExecute: begin
                aluSrcA    = 1'b1;
                aluSrcB    = 2'b10;
                extSel     = (opcode == ori);
                aluControl = (opcode == ori) ? aluOr : aluAdd;
                nextState  = immWriteback;
            end
            immWriteback: begin
                regWrite = 1'b1;
            end
            default: nextState = fetch;
        endcase
    end

endmodule

// File: datapath/regFile.sv
`timescale 1ns/1ps

module regFile
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] readAdr1,
    input  logic [regAddrWidth-1:0] readAdr2,
    input  logic [regAddrWidth-1:0] writeAdr,
    input  logic                    writeEn,
    input  logic [dataWidth-1:0]    writeData,
    output logic [dataWidth-1:0]    readData1,
    output logic [dataWidth-1:0]    readData2
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAdr != '0) begin  // Register 0 stays zero.
            regs[writeAdr] <= writeData;
        end
    end

    assign readData1 = regs[readAdr1];
    assign readData2 = regs[readAdr2];

endmodule

// File: datapath/multiplier.sv
`timescale 1ns/1ps

module multiplier
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [dataWidth-1:0] multiplicand,
    input  logic [dataWidth-1:0] multiplierIn,
    output logic                 busy,
    output logic [dataWidth-1:0] product
);

    logic [dataWidth-1:0]           acc, mcand, mplier;
    logic [$clog2(mulCycles+1)-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count + 1'b1 == mulCycles) begin
                busy <= 1'b0;
            end
        end
    end

    // Low word only, so signed operands come out right too.
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= multiplicand;
            mplier <= multiplierIn;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;

endmodule

// File: datapath/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  aluOpT                aluControl,
    input  logic [dataWidth-1:0] srcA,
    input  logic [dataWidth-1:0] srcB,
    input  logic [4:0]           shamt,
    input  logic                 start,
    output logic [dataWidth-1:0] result,
    output logic                 zero,
    output logic                 busy
);

    logic [dataWidth-1:0] product;

    multiplier i_multiplier (
        .clk(clk), .rst(rst), .start(start),
        .multiplicand(srcA), .multiplierIn(srcB),
        .busy(busy), .product(product)
    );

    always_comb begin
        case (aluControl)
            aluAdd:  result = srcA + srcB;
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluSlt:  result = {31'd0, $signed(srcA) < $signed(srcB)};
            aluSll:  result = srcB << shamt;    // Shifts act on rt, as in MIPS.
            aluSrl:  result = srcB >> shamt;
            aluMul:  result = product;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ps

module datapath
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pcEn,
    input  logic                 iorD,
    input  logic                 irWrite,
    input  logic                 regDst,
    input  logic                 memToReg,
    input  logic                 regWrite,
    input  logic                 aluSrcA,
    input  logic [1:0]           aluSrcB,
    input  logic                 extSel,
    input  logic                 pcSrc,
    input  aluOpT                aluControl,
    input  logic                 aluStart,
    input  logic [dataWidth-1:0] readData,
    output opcodeT               opcode,
    output logic [5:0]           funct,
    output logic                 zero,
    output logic                 aluBusy,
    output logic [dataWidth-1:0] dataAdr,
    output logic [dataWidth-1:0] writeData
);

    logic [dataWidth-1:0]    pc, pcNext;
    logic [dataWidth-1:0]    instr, dataReg;
    logic [dataWidth-1:0]    aReg, bReg, aluOut;
    logic [dataWidth-1:0]    rd1, rd2, regWriteData;
    logic [dataWidth-1:0]    imm, immSh;
    logic [dataWidth-1:0]    srcA, srcB, aluResult;
    logic [regAddrWidth-1:0] writeReg;

    // ==================================================================
    // State registers
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (pcEn) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) begin
            instr <= readData;
        end
        dataReg <= readData;
        aReg    <= rd1;
        bReg    <= rd2;
        aluOut  <= aluResult;
    end

    assign opcode    = opcodeT'(instr[31:26]);
    assign funct     = instr[5:0];
    assign dataAdr   = iorD ? aluOut : pc;
    assign writeData = bReg;

    // Zero extension is used only by ori.
    assign imm   = extSel ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign immSh = {imm[dataWidth-3:0], 2'b00};

    assign writeReg     = regDst ? instr[15:11] : instr[20:16];
    assign regWriteData = memToReg ? dataReg : aluOut;
    assign srcA         = aluSrcA ? aReg : pc;
    assign pcNext       = pcSrc ? aluOut : aluResult;

    always_comb begin
        case (aluSrcB)
            2'b00:   srcB = bReg;
            2'b01:   srcB = 32'd4;
            2'b10:   srcB = imm;
            default: srcB = immSh;
        endcase
    end

    regFile i_regFile (
        .clk(clk), .rst(rst),
        .readAdr1(instr[25:21]), .readAdr2(instr[20:16]),
        .writeAdr(writeReg), .writeEn(regWrite), .writeData(regWriteData),
        .readData1(rd1), .readData2(rd2)
    );

    aluUnit i_aluUnit (
        .clk(clk), .rst(rst), .aluControl(aluControl),
        .srcA(srcA), .srcB(srcB), .shamt(instr[10:6]), .start(aluStart),
        .result(aluResult), .zero(zero), .busy(aluBusy)
    );

endmodule

// File: src/memory.sv
`timescale 1ns/1ps

module memory
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 writeEn,
    input  logic [dataWidth-1:0] adr,
    input  logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0]         mem [memWords];
    logic [$clog2(memWords)-1:0]  wordIdx;

    initial begin
        $readmemh("verification/program.hex", mem);
    end

    assign wordIdx  = adr[$clog2(memWords)+1:2];   // Byte address to word index.
    assign readData = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[wordIdx] <= writeData;
        end
    end

endmodule

// File: src/multicycleCpu.sv
`timescale 1ns/1ps

module multicycleCpu
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    output logic                 memWrite,
    output logic [dataWidth-1:0] dataAdr,
    output logic [dataWidth-1:0] writeData
);

    // ==================================================================
    // Control to datapath wiring
    // ==================================================================
    logic                 pcEn, iorD, irWrite, regDst, memToReg, regWrite;
    logic                 aluSrcA, extSel, pcSrc, aluStart;
    logic [1:0]           aluSrcB;
    aluOpT                aluControl;
    opcodeT               opcode;
    logic [5:0]           funct;
    logic                 zero, aluBusy;
    logic [dataWidth-1:0] readData;

    controller i_controller (
        .clk(clk), .rst(rst), .opcode(opcode), .funct(funct),
        .zero(zero), .aluBusy(aluBusy),
        .pcEn(pcEn), .iorD(iorD), .irWrite(irWrite), .regDst(regDst),
        .memToReg(memToReg), .regWrite(regWrite), .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB), .extSel(extSel), .pcSrc(pcSrc),
        .aluControl(aluControl), .aluStart(aluStart), .memWrite(memWrite)
    );

    datapath i_datapath (
        .clk(clk), .rst(rst), .pcEn(pcEn), .iorD(iorD), .irWrite(irWrite),
        .regDst(regDst), .memToReg(memToReg), .regWrite(regWrite),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .extSel(extSel), .pcSrc(pcSrc),
        .aluControl(aluControl), .aluStart(aluStart), .readData(readData),
        .opcode(opcode), .funct(funct), .zero(zero), .aluBusy(aluBusy),
        .dataAdr(dataAdr), .writeData(writeData)
    );

    memory i_memory (
        .clk(clk), .writeEn(memWrite), .adr(dataAdr),
        .writeData(writeData), .readData(readData)
    );

endmodule

// File: verification/cpuProps.sv
`timescale 1ns/1ps

module cpuProps
    import mipsPkg::*;
(
    input logic  clk,
    input logic  rst,
    input stateT state,
    input logic  memWrite,
    input logic  regWrite,
    input logic  aluStart,
    input logic  aluBusy
);

    int failCount = 0;

    // A store and a register write never share a cycle.
    noStoreWithRegWrite: assert property (@(posedge clk) disable iff (rst)
        !(memWrite && regWrite))
        else begin
            $error("memWrite and regWrite are high in the same cycle");
            failCount++;
        end

    startRaisesBusy: assert property (@(posedge clk) disable iff (rst)
        aluStart |=> aluBusy)
        else begin
            $error("aluBusy did not rise one cycle after aluStart");
            failCount++;
        end

    resetToFetch: assert property (@(posedge clk) rst |=> state == fetch)
        else begin
            $error("state after reset is not fetch");
            failCount++;
        end

endmodule

bind controller cpuProps i_cpuProps (
    .clk(clk), .rst(rst), .state(state), .memWrite(memWrite),
    .regWrite(regWrite), .aluStart(aluStart), .aluBusy(aluBusy)
);

// File: verification/cpuTb.sv
`timescale 1ns/1ps

module cpuTb
    import mipsPkg::*;
();

    // ==================================================================
    // Test parameters
    // ==================================================================
    localparam int clkPeriod   = 100;
    localparam int resetCycles = 5;
    localparam int numStores   = 13;
    localparam int progInstrs  = 31;   // Words in program.hex, halt loop included.
    localparam int mulCount    = 1;
    localparam int trailCycles = 16;   // Quiet time in the halt loop after the last store.
    localparam int timeoutCycles =
        progInstrs * 5 + mulCount * (mulCycles + 5) + 20 + resetCycles;

    // Operands that the program loads with addi before the R-type tests.
    localparam logic [dataWidth-1:0] opA    = -5;
    localparam logic [dataWidth-1:0] opB    = 12;
    localparam logic [15:0]          immVal = 16'h8001;

    logic                 clk;
    logic                 rst;
    logic                 memWrite;
    logic [dataWidth-1:0] dataAdr;
    logic [dataWidth-1:0] writeData;

    logic [dataWidth-1:0] expAdr  [numStores];
    logic [dataWidth-1:0] expData [numStores];
    string                expName [numStores];

    int storeIdx = 0;
    int errors   = 0;
    int checks   = 0;

    multicycleCpu i_multicycleCpu (
        .clk(clk), .rst(rst), .memWrite(memWrite),
        .dataAdr(dataAdr), .writeData(writeData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic addRow(input int idx, input logic [dataWidth-1:0] adr,
                          input logic [dataWidth-1:0] data, input string name);
        expAdr[idx]  = adr;
        expData[idx] = data;
        expName[idx] = name;
    endtask

    // Expected stores in program order. The marker store at 0xa8 sits behind a taken beq.
    task automatic fillTable;
        addRow(0,  32'h80, opA + opB, "add");
        addRow(1,  32'h84, opA - opB, "sub");
        addRow(2,  32'h88, opA & opB, "and");
        addRow(3,  32'h8c, opA | opB, "or");
        addRow(4,  32'h90, (int'(opA) < int'(opB)) ? 32'd1 : 32'd0, "slt");
        addRow(5,  32'h94, opB << 4, "sll");             // Shift amount 4.
        addRow(6,  32'h98, opA >> 28, "srl");            // Shift amount 28.
        addRow(7,  32'h9c, {{16{immVal[15]}}, immVal}, "addi sign extension");
        addRow(8,  32'ha0, {16'h0000, immVal}, "ori zero extension");
        addRow(9,  32'ha4, (opA + opB) + (opA + opB), "lw round trip");
        addRow(10, 32'hac, opB, "beq not taken");
        addRow(11, 32'hb0, opA * opB, "mul low word");
        addRow(12, 32'hb4, (opA + opB) + (opA + opB), "store after mul");
    endtask

    task automatic checkStore;
        if (storeIdx >= numStores) begin
            $display("Unexpected store to address %h after all %0d expected stores",
                     dataAdr, numStores);
            errors++;
        end else begin
            checks++;
            if (dataAdr !== expAdr[storeIdx]) begin
                $display("Error: dataAdr = %h, expected %h (%s)",
                         dataAdr, expAdr[storeIdx], expName[storeIdx]);
                errors++;
            end
            if (writeData !== expData[storeIdx]) begin
                $display("Error: writeData = %h, expected %h (%s)",
                         writeData, expData[storeIdx], expName[storeIdx]);
                errors++;
            end
            storeIdx++;
        end
    endtask

    // No store may be issued while the CPU is held in reset.
    always @(negedge clk) begin
        if (rst && memWrite !== 1'b0) begin
            $display("Error: memWrite = %h during reset, expected 0", memWrite);
            errors++;
        end
    end

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        rst = 1'b1;
        fillTable();
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;

        for (int i = 0; i < numStores; i++) begin
            do begin
                @(negedge clk);
            end while (memWrite !== 1'b1);
            checkStore();
        end

        // The program ends in a beq to itself, so nothing more may be stored.
        repeat (trailCycles) begin
            @(negedge clk);
            if (memWrite !== 1'b0) begin
                checkStore();
            end
        end

        errors += i_multicycleCpu.i_controller.i_cpuProps.failCount;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(clkPeriod * timeoutCycles);
        $display("Timeout after %0d cycles, %0d of %0d stores never arrived",
                 timeoutCycles, numStores - storeIdx, numStores);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verification/program.hex
// One instruction word per line, loaded from word address 0.
// Data stores go to byte addresses 0x80 and up, past the program.
2001FFFB  // addi $1, $0, -5
2002000C  // addi $2, $0, 12
00221820  // add  $3, $1, $2
AC030080  // sw   $3, 0x80($0)
00222022  // sub  $4, $1, $2
AC040084  // sw   $4, 0x84($0)
00222824  // and  $5, $1, $2
AC050088  // sw   $5, 0x88($0)
00223025  // or   $6, $1, $2
AC06008C  // sw   $6, 0x8c($0)
0022382A  // slt  $7, $1, $2
AC070090  // sw   $7, 0x90($0)
00024100  // sll  $8, $2, 4
AC080094  // sw   $8, 0x94($0)
00014F02  // srl  $9, $1, 28
AC090098  // sw   $9, 0x98($0)
200A8001  // addi $10, $0, 0x8001
AC0A009C  // sw   $10, 0x9c($0)
340B8001  // ori  $11, $0, 0x8001
AC0B00A0  // sw   $11, 0xa0($0)
8C0C0080  // lw   $12, 0x80($0)
018C6820  // add  $13, $12, $12
AC0D00A4  // sw   $13, 0xa4($0)
10630001  // beq  $3, $3, 1 (taken)
AC0100A8  // sw   $1, 0xa8($0) (marker, skipped)
10220001  // beq  $1, $2, 1 (not taken)
AC0200AC  // sw   $2, 0xac($0)
00227018  // mul  $14, $1, $2
AC0E00B0  // sw   $14, 0xb0($0)
AC0D00B4  // sw   $13, 0xb4($0)
1000FFFF  // beq  $0, $0, -1 (halt)

// File: flist.f
common/mipsPkg.sv
src/controller.sv
datapath/regFile.sv
datapath/multiplier.sv
datapath/aluUnit.sv
datapath/datapath.sv
src/memory.sv
src/multicycleCpu.sv
verification/cpuProps.sv
verification/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cpuTb -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "Testbench reported failure"
    exit 1
fi
echo "Testbench reported no failure"
